// ==== common/icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Byte address width of the fetch pc
`define ICACHE_ADDR_WIDTH 32

// 32-bit words in one cache block
`define ICACHE_WORDS_PER_BLOCK 4

// Sets per way
`define ICACHE_SETS 16

`endif

// ==== common/icache_pkg.sv ====
`include "icache_config.svh"

package icache_pkg;

    localparam int ADDR_W = `ICACHE_ADDR_WIDTH;
    localparam int INDEX_W = $clog2(`ICACHE_SETS);
    localparam int WORD_W = $clog2(`ICACHE_WORDS_PER_BLOCK);
    localparam int BYTE_W = 2;
    localparam int TAG_W = ADDR_W - INDEX_W - WORD_W - BYTE_W;

    // L2 sees only the block address
    localparam int BLOCK_ADDR_W = TAG_W + INDEX_W;

    typedef logic [TAG_W-1:0] tag_t;

    // Word 0 sits at the low end
    typedef logic [`ICACHE_WORDS_PER_BLOCK-1:0][31:0] block_t;

    typedef struct packed {
        tag_t                tag;
        logic [INDEX_W-1:0]  index;
        logic [WORD_W-1:0]   word;
        logic [BYTE_W-1:0]   byte_off;
    } addr_fields_t;

    typedef struct packed {
        addr_fields_t  pc;
        logic          way;
    } miss_t;

    typedef struct packed {
        logic                en;
        logic                way;
        logic [INDEX_W-1:0]  index;
        tag_t                tag;
        block_t              block;
    } fill_t;

endpackage

// ==== rtl/icache_way_ram.sv ====
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_way_ram #(
    parameter type payload_t = icache_pkg::tag_t
) (
    input  logic                            CLK,
    input  logic [icache_pkg::INDEX_W-1:0]  rd_index,
    input  logic                            rd_en,
    output payload_t                        rd_data,
    input  logic                            wr_en,
    input  logic [icache_pkg::INDEX_W-1:0]  wr_index,
    input  payload_t                        wr_data
);

    payload_t mem [`ICACHE_SETS];

    always_ff @(posedge CLK)
    begin
        if (wr_en)
        begin
            mem[wr_index] <= wr_data;
        end
    end

    // Output holds its last read while rd_en is low
    always_ff @(posedge CLK)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_index];
        end
    end

endmodule

// ==== icache/icache_lookup.sv ====
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_lookup (
    input  logic                                 CLK,
    input  logic                                 reset,
    input  logic [`ICACHE_ADDR_WIDTH-1:0]        pc,
    input  logic                                 pc_valid,
    output logic                                 pc_ready,
    input  logic                                 stall,
    output logic [31:0]                          instr,
    output logic                                 instr_valid,
    output logic [icache_pkg::INDEX_W-1:0]       rd_index,
    output logic                                 rd_en,
    input  icache_pkg::tag_t [1:0]               tag_rd,
    input  icache_pkg::block_t [1:0]             block_rd,
    output icache_pkg::miss_t                    miss,
    output logic                                 miss_valid,
    input  icache_pkg::fill_t                    fill
);

    icache_pkg::addr_fields_t       pc_fields;
    icache_pkg::addr_fields_t       st2_q;
    logic                           st2_valid_q;
    logic [1:0][`ICACHE_SETS-1:0]   valid_q;
    logic [`ICACHE_SETS-1:0]        lru_q;
    logic                           pending_q;
    logic                           filled_q;
    icache_pkg::block_t             fill_block_q;
    logic [1:0]                     way_hit;
    logic                           hit;
    logic                           st2_done;
    logic                           adv2;
    icache_pkg::block_t             st2_block;
    logic                           st3_valid_q;
    icache_pkg::block_t             st3_block_q;
    logic [icache_pkg::WORD_W-1:0]  st3_word_q;

    //////////////////////////////////////////////////
    // Stage 1 decodes the pc and starts the RAM reads
    assign pc_fields = pc;
    assign rd_index = pc_fields.index;
    assign rd_en = pc_valid && pc_ready;

    //////////////////////////////////////////////////
    // Stage 2 tag compare
    assign way_hit[0] = valid_q[0][st2_q.index] && (tag_rd[0] == st2_q.tag);
    assign way_hit[1] = valid_q[1][st2_q.index] && (tag_rd[1] == st2_q.tag);
    assign hit = |way_hit;

    // A refilled entry completes from the captured fill block
    assign st2_done = filled_q || hit;
    assign adv2 = !stall && (!st2_valid_q || st2_done);
    assign pc_ready = adv2;

    assign st2_block = filled_q ? fill_block_q : (way_hit[1] ? block_rd[1] : block_rd[0]);

    assign miss_valid = st2_valid_q && !st2_done && !pending_q;
    assign miss.pc = st2_q;
    assign miss.way = lru_q[st2_q.index];

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            st2_valid_q <= 1'b0;
            st3_valid_q <= 1'b0;
            instr_valid <= 1'b0;
            pending_q <= 1'b0;
            filled_q <= 1'b0;
            valid_q <= '0;
            lru_q <= '0;
        end
        else
        begin
            if (adv2)
            begin
                st2_valid_q <= pc_valid;
                filled_q <= 1'b0;
            end
            if (!stall)
            begin
                st3_valid_q <= st2_valid_q && st2_done;
                instr_valid <= st3_valid_q;
            end
            if (miss_valid)
            begin
                pending_q <= 1'b1;
            end
            // LRU points at the way not just used
            if (adv2 && st2_valid_q && hit && !filled_q)
            begin
                lru_q[st2_q.index] <= ~way_hit[1];
            end
            if (fill.en)
            begin
                pending_q <= 1'b0;
                filled_q <= 1'b1;
                valid_q[fill.way][fill.index] <= 1'b1;
                lru_q[fill.index] <= ~fill.way;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage 3 word select
    always_ff @(posedge CLK)
    begin
        if (adv2)
        begin
            st2_q <= pc_fields;
        end
        if (fill.en)
        begin
            fill_block_q <= fill.block;
        end
        if (!stall)
        begin
            st3_block_q <= st2_block;
            st3_word_q <= st2_q.word;
            instr <= st3_block_q[st3_word_q];
        end
    end

    // Victim choice keeps a tag in one way only
    assert property (@(posedge CLK) disable iff (reset)
        st2_valid_q |-> !(way_hit[0] && way_hit[1]));

    // Frozen from the miss until the fill returns
    assert property (@(posedge CLK) disable iff (reset)
        (miss_valid || pending_q) |-> !pc_ready);

endmodule

// ==== icache/icache_refill.sv ====
`timescale 1ns/100ps

module icache_refill (
    input  logic                                 CLK,
    input  logic                                 reset,
    input  icache_pkg::miss_t                    miss,
    input  logic                                 miss_valid,
    output logic                                 l2_addr_valid,
    output logic [icache_pkg::BLOCK_ADDR_W-1:0]  l2_addr,
    input  logic                                 l2_addr_ready,
    input  logic                                 l2_data_valid,
    input  icache_pkg::block_t                   l2_data,
    output logic                                 l2_data_ready,
    output icache_pkg::fill_t                    fill
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } state_t;

    state_t             state_q;
    icache_pkg::miss_t  req_q;

    //////////////////////////////////////////////////
    // Miss FSM
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state_q <= S_IDLE;
        end
        else
        begin
            case (state_q)
                S_IDLE:
                begin
                    if (miss_valid)
                    begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ:
                begin
                    if (l2_addr_ready)
                    begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT:
                begin
                    if (l2_data_valid)
                    begin
                        state_q <= S_IDLE;
                    end
                end
                default:
                begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state_q == S_IDLE && miss_valid)
        begin
            req_q <= miss;
        end
    end

    assign l2_addr_valid = (state_q == S_REQ);
    assign l2_addr = {req_q.pc.tag, req_q.pc.index};
    assign l2_data_ready = (state_q == S_WAIT);

    // One-cycle write of the returned block into the victim way
    assign fill.en = l2_data_ready && l2_data_valid;
    assign fill.way = req_q.way;
    assign fill.index = req_q.pc.index;
    assign fill.tag = req_q.pc.tag;
    assign fill.block = l2_data;

    // Wait-data opens only right after the address handshake
    assert property (@(posedge CLK) disable iff (reset)
        $rose(l2_data_ready) |-> $past(l2_addr_valid && l2_addr_ready));

    // Lookup freezes on a miss, so no second miss arrives mid-refill
    assert property (@(posedge CLK) disable iff (reset)
        miss_valid |-> state_q == S_IDLE);

endmodule

// ==== icache/icache_top.sv ====
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_top (
    input  logic                                 CLK,
    input  logic                                 reset,
    input  logic [`ICACHE_ADDR_WIDTH-1:0]        pc,
    input  logic                                 pc_valid,
    output logic                                 pc_ready,
    output logic [31:0]                          instr,
    output logic                                 instr_valid,
    input  logic                                 stall,
    output logic                                 l2_addr_valid,
    output logic [icache_pkg::BLOCK_ADDR_W-1:0]  l2_addr,
    input  logic                                 l2_addr_ready,
    input  logic                                 l2_data_valid,
    input  icache_pkg::block_t                   l2_data,
    output logic                                 l2_data_ready
);

    logic [icache_pkg::INDEX_W-1:0]  rd_index;
    logic                            rd_en;
    icache_pkg::tag_t [1:0]          tag_rd;
    icache_pkg::block_t [1:0]        block_rd;
    icache_pkg::miss_t               miss;
    logic                            miss_valid;
    icache_pkg::fill_t               fill;
    logic [1:0]                      way_wr;

    assign way_wr[0] = fill.en && !fill.way;
    assign way_wr[1] = fill.en && fill.way;

    icache_lookup icache_lookup_i (
        .CLK          (CLK),
        .reset        (reset),
        .pc           (pc),
        .pc_valid     (pc_valid),
        .pc_ready     (pc_ready),
        .stall        (stall),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .rd_index     (rd_index),
        .rd_en        (rd_en),
        .tag_rd       (tag_rd),
        .block_rd     (block_rd),
        .miss         (miss),
        .miss_valid   (miss_valid),
        .fill         (fill)
    );

    icache_refill icache_refill_i (
        .CLK            (CLK),
        .reset          (reset),
        .miss           (miss),
        .miss_valid     (miss_valid),
        .l2_addr_valid  (l2_addr_valid),
        .l2_addr        (l2_addr),
        .l2_addr_ready  (l2_addr_ready),
        .l2_data_valid  (l2_data_valid),
        .l2_data        (l2_data),
        .l2_data_ready  (l2_data_ready),
        .fill           (fill)
    );

    // Tag and block RAM per way
    for (genvar w = 0; w < 2; w++)
    begin : g_way
        icache_way_ram #(
            .payload_t  (icache_pkg::tag_t)
        ) tag_ram_i (
            .CLK       (CLK),
            .rd_index  (rd_index),
            .rd_en     (rd_en),
            .rd_data   (tag_rd[w]),
            .wr_en     (way_wr[w]),
            .wr_index  (fill.index),
            .wr_data   (fill.tag)
        );

        icache_way_ram #(
            .payload_t  (icache_pkg::block_t)
        ) block_ram_i (
            .CLK       (CLK),
            .rd_index  (rd_index),
            .rd_en     (rd_en),
            .rd_data   (block_rd[w]),
            .wr_en     (way_wr[w]),
            .wr_index  (fill.index),
            .wr_data   (fill.block)
        );
    end

endmodule

// ==== dv/icache_tb.sv ====
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_tb;

    localparam int BLOCK_BYTES = 4 * `ICACHE_WORDS_PER_BLOCK;
    // A miss costs about 20 cycles at worst, so the whole run fits with margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                                 CLK;
    logic                                 reset;
    logic [31:0]                          pc;
    logic                                 pc_valid;
    logic                                 pc_ready;
    logic [31:0]                          instr;
    logic                                 instr_valid;
    logic                                 stall;
    logic                                 l2_addr_valid;
    logic [icache_pkg::BLOCK_ADDR_W-1:0]  l2_addr;
    logic                                 l2_addr_ready;
    logic                                 l2_data_valid;
    icache_pkg::block_t                   l2_data;
    logic                                 l2_data_ready;

    integer       seed = 32'he8d746fb;
    int           errors = 0;
    int           cycles = 0;
    int           l2_reqs = 0;
    int           predicted_misses = 0;
    logic [31:0]  l2_last_addr;
    bit           check_latency = 1'b0;
    logic [31:0]  exp_pc [$];
    int           exp_cycle [$];

    // Reference directory, updated in program order
    icache_pkg::tag_t  m_tag [2][`ICACHE_SETS];
    logic              m_valid [2][`ICACHE_SETS] = '{default: 1'b0};
    logic              m_lru [`ICACHE_SETS] = '{default: 1'b0};

    icache_top icache_top_i (.*);

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic icache_pkg::block_t block_for(input logic [31:0] block_addr);
        icache_pkg::block_t b;
        for (int w = 0; w < `ICACHE_WORDS_PER_BLOCK; w++)
        begin
            b[w] = word_at(block_addr * BLOCK_BYTES + 4 * w);
        end
        return b;
    endfunction

    function automatic void model_access(input logic [31:0] addr);
        icache_pkg::addr_fields_t f;
        logic v;
        f = addr;
        if (m_valid[0][f.index] && m_tag[0][f.index] == f.tag)
        begin
            m_lru[f.index] = 1'b1;
        end
        else if (m_valid[1][f.index] && m_tag[1][f.index] == f.tag)
        begin
            m_lru[f.index] = 1'b0;
        end
        else
        begin
            v = m_lru[f.index];
            m_valid[v][f.index] = 1'b1;
            m_tag[v][f.index] = f.tag;
            m_lru[f.index] = !v;
            predicted_misses++;
        end
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // L2 model
    initial
    begin
        int delay;
        l2_addr_ready = 1'b0;
        l2_data_valid = 1'b0;
        l2_data = '0;
        forever
        begin
            @(posedge CLK);
            if (l2_addr_valid)
            begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge CLK);
                l2_addr_ready <= 1'b1;
                @(posedge CLK);
                l2_addr_ready <= 1'b0;
                l2_last_addr = 32'(l2_addr);
                l2_reqs++;
                delay = 2 + $unsigned($random(seed)) % 5;
                repeat (delay - 1) @(posedge CLK);
                l2_data <= block_for(l2_last_addr);
                l2_data_valid <= 1'b1;
                do
                    @(posedge CLK);
                while (!l2_data_ready);
                l2_data_valid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Fetch and result monitor
    initial
    begin
        logic [31:0] a;
        int c;
        forever
        begin
            @(posedge CLK);
            cycles++;
            if (!reset && pc_valid && pc_ready)
            begin
                exp_pc.push_back(pc);
                exp_cycle.push_back(cycles);
                model_access(pc);
            end
            if (!reset && instr_valid && !stall)
            begin
                if (exp_pc.size() == 0)
                begin
                    $display("Instruction %h came out with no fetch outstanding", instr);
                    errors++;
                end
                else
                begin
                    a = exp_pc.pop_front();
                    c = exp_cycle.pop_front();
                    check(instr, word_at(a), "instruction");
                    // Accepted at edge N, valid after N+2, seen at N+3
                    if (check_latency)
                    begin
                        check(32'(cycles - c), 32'd3, "hit latency");
                    end
                end
            end
        end
    end

    initial
    begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish in %0d cycles, %0d errors", cycles, errors);
        $display("test failed");
        $finish;
    end

    task automatic fetch(input logic [31:0] addr, output int waits);
        waits = 0;
        pc <= addr;
        pc_valid <= 1'b1;
        do
        begin
            @(posedge CLK);
            waits++;
        end
        while (!pc_ready);
        pc_valid <= 1'b0;
    endtask

    task automatic drain();
        @(posedge CLK);
        while (exp_pc.size() != 0)
        begin
            @(posedge CLK);
        end
        repeat (3) @(posedge CLK);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    task automatic cold_miss_test();
        int r0;
        int waits;
        r0 = l2_reqs;
        fetch(32'h0000_1044, waits);
        drain();
        check(32'(l2_reqs - r0), 32'd1, "cold miss L2 requests");
        check(l2_last_addr, 32'h0000_1044 / BLOCK_BYTES, "cold miss block address");
    endtask

    task automatic same_block_hits_test();
        int r0;
        int waits [3];
        r0 = l2_reqs;
        check_latency = 1'b1;
        fetch(32'h0000_1040, waits[0]);
        fetch(32'h0000_1048, waits[1]);
        fetch(32'h0000_104c, waits[2]);
        drain();
        check_latency = 1'b0;
        check(32'(waits[0] + waits[1] + waits[2]), 32'd3, "edges for three hits");
        check(32'(l2_reqs - r0), 32'd0, "hit L2 requests");
    endtask

    // Three tags in set 4, A already in way 0
    task automatic replacement_test();
        int r0;
        int waits;
        r0 = l2_reqs;
        fetch(32'h0000_1040, waits);
        fetch(32'h0000_2040, waits);
        fetch(32'h0000_1040, waits);
        fetch(32'h0000_3040, waits);
        drain();
        check(32'(l2_reqs - r0), 32'd2, "fills for B and C");
        r0 = l2_reqs;
        fetch(32'h0000_1044, waits);
        drain();
        check(32'(l2_reqs - r0), 32'd0, "refetch of A");
        fetch(32'h0000_2048, waits);
        drain();
        check(32'(l2_reqs - r0), 32'd1, "refetch of evicted B");
        check(l2_last_addr, 32'h0000_2040 / BLOCK_BYTES, "block address of B");
    endtask

    task automatic stall_test();
        int waits;
        fetch(32'h0000_1040, waits);
        fetch(32'h0000_1044, waits);
        fetch(32'h0000_1048, waits);
        // First result appears right after this edge
        stall <= 1'b1;
        @(posedge CLK);
        check(instr, word_at(32'h0000_1040), "instr entering stall");
        check(32'(instr_valid), 32'd1, "instr_valid entering stall");
        repeat (4)
        begin
            @(posedge CLK);
            check(instr, word_at(32'h0000_1040), "instr under stall");
            check(32'(instr_valid), 32'd1, "instr_valid under stall");
            check(32'(pc_ready), 32'd0, "pc_ready under stall");
        end
        stall <= 1'b0;
        drain();
    endtask

    task automatic random_stream_test();
        logic [31:0] blocks [8] = '{32'h0000_1040, 32'h0000_2040, 32'h0000_3040,
                                    32'h0000_4080, 32'h0000_5080, 32'h0000_60c0,
                                    32'h0000_70c0, 32'h0000_80c0};
        int r0;
        int p0;
        int waits;
        int pick;
        r0 = l2_reqs;
        p0 = predicted_misses;
        for (int i = 0; i < 60; i++)
        begin
            pick = $unsigned($random(seed)) % 8;
            fetch(blocks[pick] + 32'(4 * ($unsigned($random(seed)) % 4)), waits);
        end
        drain();
        check(32'(l2_reqs - r0), 32'(predicted_misses - p0), "random stream L2 requests");
    endtask

    initial
    begin
        reset = 1'b1;
        pc = '0;
        pc_valid = 1'b0;
        stall = 1'b0;
        repeat (2) @(posedge CLK);
        reset <= 1'b0;
        @(posedge CLK);
        check(32'({pc_ready, instr_valid, l2_addr_valid, l2_data_ready}), 32'b1000,
              "ready and valid flags after reset");
        cold_miss_test();
        same_block_hits_test();
        replacement_test();
        stall_test();
        random_stream_test();
        $display("Errors: %0d, L2 requests: %0d", errors, l2_reqs);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+common
common/icache_pkg.sv
rtl/icache_way_ram.sv
icache/icache_lookup.sv
icache/icache_refill.sv
icache/icache_top.sv
dv/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module icache_tb -o icache_sim

out=$(./obj_dir/icache_sim)
echo "$out"

if echo "$out" | grep -qx "test passed"
then
    exit 0
fi
exit 1
